/* Makefile */
# Verilator build and run of the AXI-stream profiler testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_axis_profile
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+.
axis_pkg.sv
prof_pkg.sv
axis_cycle_classify.sv
prof_prescale_bank.sv
prof_count_bank.sv
prof_window_timer.sv
prof_window_fsm.sv
axis_profile_top.sv
tb_axis_profile.sv

/* axis_cycle_classify.sv */
//////////////////////////////
// One cycle of latency from beat to event
// Events are forced to zero while enable is low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "prof_macros.svh"

module axis_cycle_classify (
    input  var logic                   axis,
    input  var logic                   rst_n,
    input  var axis_pkg::axis_beat_t   beat,
    input  var logic                   enable,
    output prof_pkg::prof_event_t      events
);
    import prof_pkg::*;

    prof_event_t ev_next;
    byte_num_t   keep_cnt;
    logic        xfer;
    logic        err_match;

    // Popcount of tkeep
    always_comb begin
        keep_cnt = '0;
        for (int b = 0; b < `PROF_KEEP_BYTES; b++) begin
            keep_cnt = keep_cnt + byte_num_t'(beat.tkeep[b]);
        end
    end

    assign xfer      = beat.tvalid & beat.tready;
    assign err_match = ((beat.tuser & `PROF_ERR_MASK) == `PROF_ERR_VALUE) &&
                       ((`PROF_ERR_ON_LAST == 0) || beat.tlast);   // Gate on tlast if asked

    always_comb begin
        ev_next       = '0;
        ev_next.xfer  = xfer;
        ev_next.bp    = beat.tvalid & ~beat.tready;    // Sink holding off
        ev_next.stall = ~beat.tvalid & beat.tready;    // Source starved
        ev_next.idle  = ~beat.tvalid & ~beat.tready;
        ev_next.frame = xfer & beat.tlast;
        ev_next.error = xfer & err_match;
        ev_next.bytes = xfer ? keep_cnt : '0;          // Only transferred bytes
    end

    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            events <= '0;
        end else if (enable) begin
            events <= ev_next;
        end else begin
            events <= '0;       // Outside the window
        end
    end

endmodule

`default_nettype wire

/* axis_pkg.sv */
//////////////////////////////
// Stream-side types for the profiler
//////////////////////////////
`default_nettype none

`include "prof_macros.svh"

package axis_pkg;

    typedef logic [`PROF_KEEP_BYTES-1:0] keep_t;   // One bit per byte lane
    typedef logic [`PROF_USER_WIDTH-1:0] user_t;

    // One sampled clock of the monitored link
    typedef struct packed {
        logic  tvalid;
        logic  tready;
        logic  tlast;
        keep_t tkeep;
        user_t tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

/* axis_profile_top.sv */
//////////////////////////////
// Passive AXI-stream profiler, tdata is not observed
// Report is valid window_len+3 cycles after the start edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axis_profile_top (
    input  var logic                axis,
    input  var logic                rst_n,
    input  var logic                tvalid,
    input  var logic                tready,
    input  var logic                tlast,
    input  var axis_pkg::keep_t     tkeep,
    input  var axis_pkg::user_t     tuser,
    input  var logic                start,
    input  var logic                abort,
    input  var prof_pkg::win_len_t  window_len,
    output prof_pkg::prof_report_t  report,
    output logic                    report_valid,
    output logic                    busy
);
    import axis_pkg::*;
    import prof_pkg::*;

    axis_beat_t  beat;
    prof_event_t events;
    prof_incr_t  incr;
    logic        enable;
    logic        clear;
    logic        snapshot;
    logic        timer_load;
    win_len_t    timer_duration;
    logic        expired;

    // Sampled stream as one struct
    assign beat = '{tvalid: tvalid, tready: tready, tlast: tlast, tkeep: tkeep, tuser: tuser};

    axis_cycle_classify u_classify (
        .axis   (axis),
        .rst_n  (rst_n),
        .beat   (beat),
        .enable (enable),
        .events (events)
    );

    prof_prescale_bank u_prescale (
        .axis   (axis),
        .rst_n  (rst_n),
        .clear  (clear),
        .events (events),
        .incr   (incr)
    );

    prof_count_bank u_counts (
        .axis     (axis),
        .rst_n    (rst_n),
        .clear    (clear),
        .snapshot (snapshot),
        .incr     (incr),
        .report   (report)
    );

    prof_window_timer u_timer (
        .axis     (axis),
        .rst_n    (rst_n),
        .load     (timer_load),
        .duration (timer_duration),
        .expired  (expired)
    );

    prof_window_fsm u_fsm (
        .axis           (axis),
        .rst_n          (rst_n),
        .start          (start),
        .abort          (abort),
        .window_len     (window_len),
        .expired        (expired),
        .timer_load     (timer_load),
        .timer_duration (timer_duration),
        .enable         (enable),
        .clear          (clear),
        .snapshot       (snapshot),
        .report_valid   (report_valid),
        .busy           (busy)
    );

endmodule

`default_nettype wire

/* prof_count_bank.sv */
//////////////////////////////
// Main divided counters and report register
// Frame count saturates and the rest wrap
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prof_count_bank (
    input  var logic                 axis,
    input  var logic                 rst_n,
    input  var logic                 clear,
    input  var logic                 snapshot,
    input  var prof_pkg::prof_incr_t incr,
    output prof_pkg::prof_report_t   report
);
    import prof_pkg::*;

    prof_report_t live;    // Running totals of the current window

    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            live <= '0;
        end else if (clear) begin
            live <= '0;                             // Window start
        end else begin
            if (incr.error) begin
                live.error_count <= live.error_count + 1'b1;
            end
            if (incr.frame && (live.frame_count != '1)) begin
                live.frame_count <= live.frame_count + 1'b1;   // Hold at max
            end
            if (incr.bp) begin
                live.backpressure_time <= live.backpressure_time + 1'b1;
            end
            if (incr.stall) begin
                live.stall_time <= live.stall_time + 1'b1;
            end
            if (incr.active) begin
                live.active_time <= live.active_time + 1'b1;
            end
            if (incr.idle) begin
                live.idle_time <= live.idle_time + 1'b1;
            end
            live.data_count <= live.data_count + count_t'(incr.data_incr);
        end
    end

    // Report holds until the next snapshot
    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            report <= '0;
        end else if (snapshot) begin
            report <= live;
        end
    end

endmodule

`default_nettype wire

/* prof_macros.svh */
//////////////////////////////
// Compile-time limits for the AXI-stream profiler
// All divisors lie in 1..65536 and PROF_BYTE_DIV is a power of two
//////////////////////////////
`ifndef PROF_MACROS_SVH
`define PROF_MACROS_SVH

// Widths
`define PROF_COUNT_WIDTH  32      // Divided counter width
`define PROF_KEEP_BYTES   4       // Bytes per beat, one tkeep bit each
`define PROF_USER_WIDTH   2       // tuser bits
`define PROF_WIN_WIDTH    16      // Window length width

// Divisors, each at least 1
`define PROF_WAIT_DIV     4       // Back-pressure and stall time
`define PROF_ACTIVE_DIV   4       // Transfer time
`define PROF_IDLE_DIV     8       // Idle time
`define PROF_BYTE_DIV     4       // Bytes, power of two only
`define PROF_FRAME_DIV    1
`define PROF_ERROR_DIV    1

// Error match on masked tuser
`define PROF_ERR_MASK     2'b01
`define PROF_ERR_VALUE    2'b01
`define PROF_ERR_ON_LAST  1       // 1 means only tlast beats count as errors

`define PROF_FLUSH_CYCLES 2       // Pipeline drain, at least 1

`endif

/* prof_pkg.sv */
//////////////////////////////
// Profiler types for events, increments, report and window control
//////////////////////////////
`default_nettype none

`include "prof_macros.svh"

package prof_pkg;

    typedef logic [`PROF_COUNT_WIDTH-1:0] count_t;
    typedef logic [$clog2(`PROF_KEEP_BYTES+1)-1:0] byte_num_t;   // 0..KEEP_BYTES
    typedef logic [`PROF_WIN_WIDTH-1:0] win_len_t;                // Cycles

    // Classified cycle, exactly one of xfer/bp/stall/idle set while enabled
    typedef struct packed {
        logic      xfer;
        logic      bp;
        logic      stall;
        logic      idle;
        logic      frame;    // tlast transfer
        logic      error;    // tuser match
        byte_num_t bytes;    // Valid bytes of a transfer
    } prof_event_t;

    // Divided increments into the main counters
    typedef struct packed {
        logic      error;
        logic      frame;
        logic      bp;
        logic      stall;
        logic      active;
        logic      idle;
        byte_num_t data_incr;   // Byte carry out of the remainder
    } prof_incr_t;

    typedef struct packed {
        count_t error_count;
        count_t frame_count;
        count_t backpressure_time;
        count_t stall_time;
        count_t active_time;
        count_t idle_time;
        count_t data_count;
    } prof_report_t;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_RUN,
        WIN_FLUSH,
        WIN_REPORT
    } win_state_t;

endpackage

`default_nettype wire

/* prof_prescale_bank.sv */
//////////////////////////////
// Per-class pre-divisors with one cycle of latency
// Pre-counters hold up to 16 bits so divisors stop at 65536
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "prof_macros.svh"

module prof_prescale_bank (
    input  var logic                  axis,
    input  var logic                  rst_n,
    input  var logic                  clear,
    input  var prof_pkg::prof_event_t events,
    output prof_pkg::prof_incr_t      incr
);
    import prof_pkg::*;

    //////////////////////////////
    // Class pre-counters

    localparam int N_CLS = 6;
    localparam int PRE_W = 16;

    // Index 5 down to 0 is error, frame, bp, stall, active, idle
    localparam int CLS_DIV [N_CLS-1:0] = '{
        `PROF_ERROR_DIV,
        `PROF_FRAME_DIV,
        `PROF_WAIT_DIV,
        `PROF_WAIT_DIV,
        `PROF_ACTIVE_DIV,
        `PROF_IDLE_DIV
    };

    typedef logic [PRE_W-1:0] pre_t;

    pre_t             pre_cnt [N_CLS-1:0];
    logic [N_CLS-1:0] hit;        // Class seen this cycle
    logic [N_CLS-1:0] wrap;       // Pre-counter at its last value and hit

    assign hit = {events.error, events.frame, events.bp,
                  events.stall, events.xfer, events.idle};

    always_comb begin
        for (int i = 0; i < N_CLS; i++) begin
            wrap[i] = hit[i] && (pre_cnt[i] == pre_t'(CLS_DIV[i] - 1));
        end
    end

    //////////////////////////////
    // Byte remainder

    localparam int BYTE_SHIFT = $clog2(`PROF_BYTE_DIV);
    localparam int REM_W      = (BYTE_SHIFT > 0) ? BYTE_SHIFT : 1;
    localparam int SUM_W      = $bits(byte_num_t) + REM_W + 1;

    logic [REM_W-1:0] byte_rem;
    logic [SUM_W-1:0] byte_sum;
    byte_num_t        data_carry;

    assign byte_sum   = SUM_W'(byte_rem) + SUM_W'(events.bytes);
    assign data_carry = byte_num_t'(byte_sum >> BYTE_SHIFT);   // Whole divisor units

    //////////////////////////////
    // Registers

    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CLS; i++) begin
                pre_cnt[i] <= '0;
            end
            byte_rem <= '0;
            incr     <= '0;
        end else if (clear) begin
            for (int i = 0; i < N_CLS; i++) begin
                pre_cnt[i] <= '0;
            end
            byte_rem <= '0;
            incr     <= '0;       // Drop any pending pulse
        end else begin
            for (int i = 0; i < N_CLS; i++) begin
                if (wrap[i]) begin
                    pre_cnt[i] <= '0;
                end else if (hit[i]) begin
                    pre_cnt[i] <= pre_cnt[i] + 1'b1;
                end
            end
            byte_rem       <= REM_W'(byte_sum & SUM_W'(`PROF_BYTE_DIV - 1));
            incr.error     <= wrap[5];
            incr.frame     <= wrap[4];
            incr.bp        <= wrap[3];
            incr.stall     <= wrap[2];
            incr.active    <= wrap[1];
            incr.idle      <= wrap[0];
            incr.data_incr <= data_carry;
        end
    end

endmodule

`default_nettype wire

/* prof_window_fsm.sv */
//////////////////////////////
// Window control, start is ignored while busy
// window_len must be at least 1
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "prof_macros.svh"

module prof_window_fsm (
    input  var logic               axis,
    input  var logic               rst_n,
    input  var logic               start,
    input  var logic               abort,
    input  var prof_pkg::win_len_t window_len,
    input  var logic               expired,
    output logic                   timer_load,
    output prof_pkg::win_len_t     timer_duration,
    output logic                   enable,
    output logic                   clear,
    output logic                   snapshot,
    output logic                   report_valid,
    output logic                   busy
);
    import prof_pkg::*;

    win_state_t state;
    win_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            WIN_IDLE: begin
                if (start) begin
                    state_nxt = WIN_RUN;
                end
            end
            WIN_RUN: begin
                if (abort) begin
                    state_nxt = WIN_IDLE;       // No report
                end else if (expired) begin
                    state_nxt = WIN_FLUSH;
                end
            end
            WIN_FLUSH: begin
                if (abort) begin
                    state_nxt = WIN_IDLE;
                end else if (expired) begin
                    state_nxt = WIN_REPORT;     // Pipeline drained
                end
            end
            default: state_nxt = WIN_IDLE;      // Report lasts one cycle
        endcase
    end

    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            state <= WIN_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Timer runs the window, then the drain
    assign timer_load     = ((state == WIN_IDLE) && start) ||
                            ((state == WIN_RUN) && expired && !abort);
    assign timer_duration = (state == WIN_RUN) ? win_len_t'(`PROF_FLUSH_CYCLES - 1)
                                               : window_len;

    assign enable       = (state == WIN_RUN) && !expired;   // Sample edges E+1..E+len
    assign clear        = (state == WIN_IDLE) && start;
    assign snapshot     = (state == WIN_FLUSH) && expired && !abort;
    assign report_valid = (state == WIN_REPORT);            // Report loaded on this edge
    assign busy         = (state != WIN_IDLE);

endmodule

`default_nettype wire

/* prof_window_timer.sv */
//////////////////////////////
// Expires duration+1 cycles after the load edge, then stops
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prof_window_timer (
    input  var logic               axis,
    input  var logic               rst_n,
    input  var logic               load,
    input  var prof_pkg::win_len_t duration,
    output logic                   expired
);
    import prof_pkg::*;

    win_len_t count;
    logic     running;

    always_ff @(posedge axis or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= duration;        // Reload wins over a running count
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;        // Stop after the pulse
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign expired = running && (count == '0);   // Last count reached

endmodule

`default_nettype wire

/* tb_axis_profile.sv */
//////////////////////////////
// Stimulus changes on the falling edge, outputs are checked there too
// Expected counts come from a cycle model of the window rules
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "prof_macros.svh"

module tb_axis_profile;
    import axis_pkg::*;
    import prof_pkg::*;

    localparam int HALF_PERIOD    = 20;   // 40 ns clock
    localparam int TIMEOUT_CYCLES = 64;   // Slack past the expected report

    logic         axis;
    logic         rst_n;
    logic         tvalid;
    logic         tready;
    logic         tlast;
    keep_t        tkeep;
    user_t        tuser;
    logic         start;
    logic         abort;
    win_len_t     window_len;
    prof_report_t report;
    logic         report_valid;
    logic         busy;

    logic [31:0]  lfsr_state;
    axis_beat_t   directed_q [$];   // Hand-made beats for the error rule

    // Raw totals of the model
    int           n_xfer;
    int           n_bp;
    int           n_stall;
    int           n_idle;
    int           n_frame;
    int           n_err;
    int           n_bytes;
    prof_report_t expected;

    axis_profile_top UUT (
        .axis         (axis),
        .rst_n        (rst_n),
        .tvalid       (tvalid),
        .tready       (tready),
        .tlast        (tlast),
        .tkeep        (tkeep),
        .tuser        (tuser),
        .start        (start),
        .abort        (abort),
        .window_len   (window_len),
        .report       (report),
        .report_valid (report_valid),
        .busy         (busy)
    );

    initial begin
        axis = 1'b0;
        forever #HALF_PERIOD axis = ~axis;
    end

    //////////////////////////////
    // Random source and reporting

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_bit()};       // One step per bit
        end
        return v;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_field(input string name, input count_t got, input count_t exp);
        assert (got == exp) else
            stop_on_failure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    task automatic compare_report(input prof_report_t exp);
        check_field("error_count", report.error_count, exp.error_count);
        check_field("frame_count", report.frame_count, exp.frame_count);
        check_field("backpressure_time", report.backpressure_time, exp.backpressure_time);
        check_field("stall_time", report.stall_time, exp.stall_time);
        check_field("active_time", report.active_time, exp.active_time);
        check_field("idle_time", report.idle_time, exp.idle_time);
        check_field("data_count", report.data_count, exp.data_count);
    endtask

    //////////////////////////////
    // Stream driver and model

    function automatic axis_beat_t make_beat(input logic v, input logic r, input logic l,
                                             input keep_t k, input user_t u);
        axis_beat_t b;
        b.tvalid = v;
        b.tready = r;
        b.tlast  = l;
        b.tkeep  = k;
        b.tuser  = u;
        return b;
    endfunction

    task automatic apply_beat(input axis_beat_t b);
        tvalid = b.tvalid;
        tready = b.tready;
        tlast  = b.tlast;
        tkeep  = b.tkeep;
        tuser  = b.tuser;
    endtask

    task automatic drive_random_beat();
        axis_beat_t b;
        b.tvalid = lfsr_bit();
        b.tready = lfsr_bit();
        b.tlast  = lfsr_bit();
        b.tkeep  = keep_t'(lfsr_bits(`PROF_KEEP_BYTES));
        b.tuser  = user_t'(lfsr_bits(`PROF_USER_WIDTH));
        apply_beat(b);
    endtask

    task automatic clear_model();
        n_xfer  = 0;
        n_bp    = 0;
        n_stall = 0;
        n_idle  = 0;
        n_frame = 0;
        n_err   = 0;
        n_bytes = 0;
    endtask

    // Classifies the beat now on the pins
    task automatic record_beat();
        if (tvalid && tready) begin
            n_xfer++;
            n_bytes += $countones(tkeep);
            if (tlast) begin
                n_frame++;                  // Frame end
            end
            if (((tuser & `PROF_ERR_MASK) == `PROF_ERR_VALUE) &&
                (tlast || (`PROF_ERR_ON_LAST == 0))) begin
                n_err++;
            end
        end else if (tvalid) begin
            n_bp++;                         // Sink not ready
        end else if (tready) begin
            n_stall++;                      // No data offered
        end else begin
            n_idle++;
        end
    endtask

    // Floor of each raw total over its divisor
    task automatic build_expected();
        longint frames;
        frames = longint'(n_frame / `PROF_FRAME_DIV);
        if (frames > longint'(count_t'('1))) begin
            frames = longint'(count_t'('1));   // Frame count holds at max
        end
        expected.error_count       = count_t'(n_err / `PROF_ERROR_DIV);
        expected.frame_count       = count_t'(frames);
        expected.backpressure_time = count_t'(n_bp / `PROF_WAIT_DIV);
        expected.stall_time        = count_t'(n_stall / `PROF_WAIT_DIV);
        expected.active_time       = count_t'(n_xfer / `PROF_ACTIVE_DIV);
        expected.idle_time         = count_t'(n_idle / `PROF_IDLE_DIV);
        expected.data_count        = count_t'(n_bytes / `PROF_BYTE_DIV);
    endtask

    //////////////////////////////
    // Window sequences

    // Negedge n lies between edges E+n-1 and E+n, beats of n = 1..len count
    task automatic run_window(input int len, input bit directed, input bit extra_starts);
        int n;
        bit seen;
        @(negedge axis);
        assert (!busy && !report_valid) else
            stop_on_failure($sformatf("Error at %0t ns: busy or report_valid before start",
                                      $time));
        clear_model();
        start      = 1'b1;
        window_len = win_len_t'(len);
        drive_random_beat();                // Sampled at E, outside the window
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge axis);
            n++;
            start = 1'b0;
            if (n > len + TIMEOUT_CYCLES) begin
                stop_on_failure("Timed out waiting for report_valid");
            end
            assert (report_valid == (n == len + 4)) else
                stop_on_failure($sformatf("Error at %0t ns: report_valid is %0b at cycle %0d",
                                          $time, report_valid, n));
            assert (busy == (n <= len + 4)) else
                stop_on_failure($sformatf("Error at %0t ns: busy is %0b at cycle %0d",
                                          $time, busy, n));
            if (n <= len + 3) begin
                compare_report(expected);   // Previous report until the snapshot
            end
            seen = report_valid;
            if (extra_starts && (n <= len + 3)) begin
                start = lfsr_bit();         // Ignored while busy
            end
            if (directed && (n <= len)) begin
                apply_beat(directed_q[n-1]);
            end else begin
                drive_random_beat();
            end
            if (n <= len) begin
                record_beat();
            end
        end
        start = 1'b0;
        build_expected();
        compare_report(expected);
        @(negedge axis);
        assert (!report_valid && !busy) else
            stop_on_failure($sformatf("Error at %0t ns: report_valid or busy after report",
                                      $time));
        compare_report(expected);           // Report held
    endtask

    task automatic abort_window(input int len);
        @(negedge axis);
        start      = 1'b1;
        window_len = win_len_t'(len);
        drive_random_beat();
        for (int n = 1; n <= len + TIMEOUT_CYCLES; n++) begin
            @(negedge axis);
            start = 1'b0;
            abort = (n == len / 2);         // Mid run
            assert (!report_valid) else
                stop_on_failure($sformatf("Error at %0t ns: report_valid after abort",
                                          $time));
            compare_report(expected);       // No snapshot without a report
            drive_random_beat();
        end
        abort = 1'b0;
        assert (!busy) else
            stop_on_failure($sformatf("Error at %0t ns: busy after abort", $time));
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        lfsr_state = 32'h8c87fcb5;
        rst_n      = 1'b0;
        tvalid     = 1'b0;
        tready     = 1'b0;
        tlast      = 1'b0;
        tkeep      = '0;
        tuser      = '0;
        start      = 1'b0;
        abort      = 1'b0;
        window_len = '0;
        repeat (3) @(posedge axis);
        @(negedge axis);
        rst_n = 1'b1;
        @(negedge axis);
        assert (!report_valid && !busy) else
            stop_on_failure($sformatf("Error at %0t ns: report_valid or busy after reset",
                                      $time));
        expected = '0;                      // Report is zero out of reset
        compare_report(expected);

        run_window(200, 1'b0, 1'b0);        // Random traffic and timing
        run_window(120, 1'b0, 1'b1);        // Own traffic only, extra starts
        abort_window(150);
        run_window(200, 1'b0, 1'b0);        // Full window after abort

        // Error rule, tuser match needs tlast and the masked bit
        directed_q.push_back(make_beat(1'b1, 1'b1, 1'b0, 4'hF, 2'b01));
        directed_q.push_back(make_beat(1'b1, 1'b1, 1'b1, 4'h3, 2'b10));
        directed_q.push_back(make_beat(1'b1, 1'b1, 1'b1, 4'h1, 2'b11));
        directed_q.push_back(make_beat(1'b1, 1'b1, 1'b1, 4'hF, 2'b01));
        directed_q.push_back(make_beat(1'b1, 1'b0, 1'b1, 4'hF, 2'b01));
        directed_q.push_back(make_beat(1'b0, 1'b1, 1'b1, 4'hF, 2'b01));
        directed_q.push_back(make_beat(1'b0, 1'b0, 1'b0, 4'h0, 2'b00));
        run_window(directed_q.size(), 1'b1, 1'b0);
        check_field("error_count of directed beats", report.error_count, count_t'(2));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
